// File: build.f
+incdir+include
rtl/axi_fifo_pkg.sv
rtl/axi_wr_ctrl.sv
rtl/strb_mod_enc.sv
rtl/fifo_word_pack.sv
rtl/axi_fifo_bridge.sv
verif/axi_fifo_bridge_asserts.sv
verif/tb_axi_fifo_bridge.sv

// File: include/axi_fifo_defs.svh
//******************************
// axi to fifo bridge widths
// and tagged word field positions
//******************************

`ifndef AXI_FIFO_DEFS_SVH
`define AXI_FIFO_DEFS_SVH

// axi side
`define AXI_ADDR_WIDTH   36
`define AXI_DATA_BYTES   64
`define AXI_DATA_WIDTH   512

// fifo word fields
`define MOD_WIDTH        6
`define CHAN_WIDTH       4
`define LEN_WIDTH        16

`define FIFO_WORD_WIDTH  540
`define CMD_WORD_WIDTH   51

// lsb of each field above the 512 data bits
`define MOD_POS          512
`define EOP_POS          518
`define SOP_POS          519
`define CHAN_POS         520
`define LEN_POS          524

`endif

// File: rtl/axi_fifo_bridge.sv
//******************************
// axi4 write slave to tagged fifo bridge
//******************************

`timescale 1ns/1ps

module axi_fifo_bridge (
    input  logic                     clk_sys,
    input  logic                     rst,

    // axi write address
    input  axi_fifo_pkg::id_t        m_awid,
    input  axi_fifo_pkg::addr_t      m_awaddr,
    input  axi_fifo_pkg::burst_len_t m_awlen,
    input  axi_fifo_pkg::size_t      m_awsize,
    input  logic                     m_awvalid,
    output logic                     s_awready,

    // axi write data
    input  axi_fifo_pkg::data_t      m_wdata,
    input  axi_fifo_pkg::strb_t      m_wstrb,
    input  logic                     m_wlast,
    input  logic                     m_wvalid,
    output logic                     s_wready,

    // axi write response, always OKAY
    output axi_fifo_pkg::id_t        s_bid,
    output logic                     s_bvalid,
    input  logic                     m_bready,

    // data fifo
    output logic                     axi2fifo_wr,
    output axi_fifo_pkg::fifo_word_t axi2fifo_wdata,
    input  logic                     fifo2axi_ff,

    // command fifo, full flag not acted on
    output logic                     axi2fifo_cmd_wr,
    output axi_fifo_pkg::cmd_word_t  axi2fifo_cmd_wdata,
    input  logic                     fifo2axi_cmd_ff,

    output axi_fifo_pkg::len_t       frame_len,
    output logic                     tran_cnt_en,
    output logic                     tranok_cnt_en,
    output logic                     frm_cnt_en
);

    logic                     beat_acc;
    logic                     beat_vld;
    logic                     beat_sop;
    logic                     beat_eop;
    axi_fifo_pkg::data_t      beat_data;
    axi_fifo_pkg::mod_t       beat_mod;
    axi_fifo_pkg::burst_len_t burst_len;
    axi_fifo_pkg::size_t      burst_size;
    axi_fifo_pkg::id_t        burst_id;
    axi_fifo_pkg::addr_t      burst_addr;
    axi_fifo_pkg::chan_t      burst_chan;

    axi_wr_ctrl u_ctrl (
        .clk_sys       (clk_sys),
        .rst           (rst),
        .m_awid        (m_awid),
        .m_awaddr      (m_awaddr),
        .m_awlen       (m_awlen),
        .m_awsize      (m_awsize),
        .m_awvalid     (m_awvalid),
        .m_wlast       (m_wlast),
        .m_wvalid      (m_wvalid),
        .m_bready      (m_bready),
        .fifo2axi_ff   (fifo2axi_ff),
        .s_awready     (s_awready),
        .s_wready      (s_wready),
        .s_bvalid      (s_bvalid),
        .s_bid         (s_bid),
        .beat_acc      (beat_acc),
        .beat_vld      (beat_vld),
        .beat_sop      (beat_sop),
        .beat_eop      (beat_eop),
        .burst_len     (burst_len),
        .burst_size    (burst_size),
        .burst_id      (burst_id),
        .burst_addr    (burst_addr),
        .burst_chan    (burst_chan),
        .tran_cnt_en   (tran_cnt_en),
        .tranok_cnt_en (tranok_cnt_en)
    );

    // data path runs beside the control block
    strb_mod_enc u_enc (
        .clk_sys   (clk_sys),
        .beat_acc  (beat_acc),
        .m_wdata   (m_wdata),
        .m_wstrb   (m_wstrb),
        .beat_data (beat_data),
        .beat_mod  (beat_mod)
    );

    fifo_word_pack u_pack (
        .clk_sys            (clk_sys),
        .rst                (rst),
        .beat_vld           (beat_vld),
        .beat_sop           (beat_sop),
        .beat_eop           (beat_eop),
        .beat_data          (beat_data),
        .beat_mod           (beat_mod),
        .burst_len          (burst_len),
        .burst_size         (burst_size),
        .burst_id           (burst_id),
        .burst_addr         (burst_addr),
        .burst_chan         (burst_chan),
        .axi2fifo_wr        (axi2fifo_wr),
        .axi2fifo_wdata     (axi2fifo_wdata),
        .axi2fifo_cmd_wr    (axi2fifo_cmd_wr),
        .axi2fifo_cmd_wdata (axi2fifo_cmd_wdata),
        .frame_len          (frame_len),
        .frm_cnt_en         (frm_cnt_en)
    );

endmodule

// File: rtl/axi_fifo_pkg.sv
//******************************
// axi to fifo bridge types
//******************************

`include "axi_fifo_defs.svh"

package axi_fifo_pkg;

    typedef logic [`AXI_ADDR_WIDTH-1:0]  addr_t;
    typedef logic [`AXI_DATA_WIDTH-1:0]  data_t;
    typedef logic [`AXI_DATA_BYTES-1:0]  strb_t;
    typedef logic [3:0]                  id_t;
    // axi encoding, beats minus one
    typedef logic [7:0]                  burst_len_t;
    typedef logic [2:0]                  size_t;
    typedef logic [`CHAN_WIDTH-1:0]      chan_t;
    typedef logic [`MOD_WIDTH-1:0]       mod_t;
    typedef logic [`LEN_WIDTH-1:0]       len_t;
    typedef logic [`FIFO_WORD_WIDTH-1:0] fifo_word_t;
    typedef logic [`CMD_WORD_WIDTH-1:0]  cmd_word_t;

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_RECV,
        ST_ACK,
        ST_BUSY
    } wr_state_e;

endpackage

// File: rtl/axi_wr_ctrl.sv
//******************************
// axi write burst control
// FSM, handshakes, burst fields and beat flags
//******************************

`timescale 1ns/1ps
`include "axi_fifo_defs.svh"

module axi_wr_ctrl (
    input  logic                     clk_sys,
    input  logic                     rst,

    input  axi_fifo_pkg::id_t        m_awid,
    input  axi_fifo_pkg::addr_t      m_awaddr,
    input  axi_fifo_pkg::burst_len_t m_awlen,
    input  axi_fifo_pkg::size_t      m_awsize,
    input  logic                     m_awvalid,
    input  logic                     m_wlast,
    input  logic                     m_wvalid,
    input  logic                     m_bready,
    input  logic                     fifo2axi_ff,

    output logic                     s_awready,
    output logic                     s_wready,
    output logic                     s_bvalid,
    output axi_fifo_pkg::id_t        s_bid,

    output logic                     beat_acc,
    output logic                     beat_vld,
    output logic                     beat_sop,
    output logic                     beat_eop,
    output axi_fifo_pkg::burst_len_t burst_len,
    output axi_fifo_pkg::size_t      burst_size,
    output axi_fifo_pkg::id_t        burst_id,
    output axi_fifo_pkg::addr_t      burst_addr,
    output axi_fifo_pkg::chan_t      burst_chan,

    output logic                     tran_cnt_en,
    output logic                     tranok_cnt_en
);

    axi_fifo_pkg::wr_state_e state;
    axi_fifo_pkg::wr_state_e state_nxt;

    logic aw_acc;
    logic last_acc;
    logic b_acc;
    // next accepted beat opens the burst
    logic first_pend;

    assign aw_acc   = m_awvalid & s_awready;
    assign beat_acc = m_wvalid & s_wready;
    assign last_acc = beat_acc & m_wlast;
    assign b_acc    = s_bvalid & m_bready;
    assign s_bid    = burst_id;

    //******************************
    // state machine
    //******************************
    always_comb begin
        state_nxt = state;
        case (state)
            axi_fifo_pkg::ST_IDLE: begin
                if (aw_acc) begin
                    state_nxt = axi_fifo_pkg::ST_RECV;
                end else if (fifo2axi_ff) begin
                    state_nxt = axi_fifo_pkg::ST_BUSY;
                end
            end
            axi_fifo_pkg::ST_RECV: begin
                // wlast alone is not enough, the beat must be taken
                if (last_acc) begin
                    state_nxt = axi_fifo_pkg::ST_ACK;
                end
            end
            axi_fifo_pkg::ST_ACK: begin
                if (b_acc) begin
                    state_nxt = fifo2axi_ff ? axi_fifo_pkg::ST_BUSY : axi_fifo_pkg::ST_IDLE;
                end
            end
            axi_fifo_pkg::ST_BUSY: begin
                if (!fifo2axi_ff) begin
                    state_nxt = axi_fifo_pkg::ST_IDLE;
                end
            end
            default: state_nxt = axi_fifo_pkg::ST_IDLE;
        endcase
    end

    // registered ready / valid outputs follow the current state
    always_ff @(posedge clk_sys or posedge rst) begin
        if (rst) begin
            state     <= axi_fifo_pkg::ST_IDLE;
            s_awready <= 1'b1;
            s_wready  <= 1'b0;
            s_bvalid  <= 1'b0;
        end else begin
            state <= state_nxt;
            case (state)
                axi_fifo_pkg::ST_IDLE: begin
                    if (aw_acc) begin
                        s_awready <= 1'b0;
                        s_wready  <= 1'b1;
                    end else if (fifo2axi_ff) begin
                        s_awready <= 1'b0;
                    end
                end
                axi_fifo_pkg::ST_RECV: begin
                    if (last_acc) begin
                        s_wready <= 1'b0;
                        s_bvalid <= 1'b1;
                    end
                end
                axi_fifo_pkg::ST_ACK: begin
                    if (b_acc) begin
                        s_bvalid  <= 1'b0;
                        s_awready <= ~fifo2axi_ff;
                    end
                end
                axi_fifo_pkg::ST_BUSY: begin
                    s_awready <= ~fifo2axi_ff;
                end
            endcase
        end
    end

    //******************************
    // burst fields and beat flags
    //******************************
    always_ff @(posedge clk_sys) begin
        if (aw_acc) begin
            burst_len  <= m_awlen;
            burst_size <= m_awsize;
            burst_id   <= m_awid;
            burst_addr <= m_awaddr;
            burst_chan <= m_awaddr[`CHAN_WIDTH-1:0];
        end
    end

    always_ff @(posedge clk_sys or posedge rst) begin
        if (rst) begin
            first_pend    <= 1'b0;
            beat_vld      <= 1'b0;
            beat_sop      <= 1'b0;
            beat_eop      <= 1'b0;
            tran_cnt_en   <= 1'b0;
            tranok_cnt_en <= 1'b0;
        end else begin
            if (aw_acc) begin
                first_pend <= 1'b1;
            end else if (beat_acc) begin
                first_pend <= 1'b0;
            end
            beat_vld      <= beat_acc;
            beat_sop      <= beat_acc & first_pend;
            beat_eop      <= last_acc;
            tran_cnt_en   <= aw_acc;
            tranok_cnt_en <= b_acc;
        end
    end

endmodule

// File: rtl/fifo_word_pack.sv
//******************************
// fifo word and command packer
// also frame length and frame pulse
//******************************

`timescale 1ns/1ps
`include "axi_fifo_defs.svh"

module fifo_word_pack (
    input  logic                      clk_sys,
    input  logic                      rst,

    input  logic                      beat_vld,
    input  logic                      beat_sop,
    input  logic                      beat_eop,
    input  axi_fifo_pkg::data_t       beat_data,
    input  axi_fifo_pkg::mod_t        beat_mod,
    input  axi_fifo_pkg::burst_len_t  burst_len,
    input  axi_fifo_pkg::size_t       burst_size,
    input  axi_fifo_pkg::id_t         burst_id,
    input  axi_fifo_pkg::addr_t       burst_addr,
    input  axi_fifo_pkg::chan_t       burst_chan,

    output logic                      axi2fifo_wr,
    output axi_fifo_pkg::fifo_word_t  axi2fifo_wdata,
    output logic                      axi2fifo_cmd_wr,
    output axi_fifo_pkg::cmd_word_t   axi2fifo_cmd_wdata,
    output axi_fifo_pkg::len_t        frame_len,
    output logic                      frm_cnt_en
);

    axi_fifo_pkg::len_t       beats;
    axi_fifo_pkg::len_t       word_len;
    axi_fifo_pkg::fifo_word_t word_nxt;
    logic                     eop_wr;

    // byte length, beats times 64 minus the tail
    assign beats    = axi_fifo_pkg::len_t'(burst_len) + axi_fifo_pkg::len_t'(1);
    assign word_len = beats * axi_fifo_pkg::len_t'(`AXI_DATA_BYTES)
                      - axi_fifo_pkg::len_t'(beat_mod);

    always_comb begin
        word_nxt                                 = '0;
        word_nxt[`MOD_POS-1:0]                   = beat_data;
        word_nxt[`EOP_POS-1:`MOD_POS]            = beat_mod;
        word_nxt[`EOP_POS]                       = beat_eop;
        word_nxt[`SOP_POS]                       = beat_sop;
        word_nxt[`LEN_POS-1:`CHAN_POS]           = burst_chan;
        word_nxt[`FIFO_WORD_WIDTH-1:`LEN_POS]    = word_len;
    end

    //******************************
    // stage 2 writes
    //******************************
    always_ff @(posedge clk_sys) begin
        if (beat_vld) begin
            axi2fifo_wdata <= word_nxt;
        end
        // burst fields still hold this burst when its eop word passes
        if (beat_vld && beat_eop) begin
            axi2fifo_cmd_wdata <= {burst_len, burst_size, burst_id, burst_addr};
        end
    end

    always_ff @(posedge clk_sys or posedge rst) begin
        if (rst) begin
            axi2fifo_wr     <= 1'b0;
            axi2fifo_cmd_wr <= 1'b0;
        end else begin
            axi2fifo_wr     <= beat_vld;
            axi2fifo_cmd_wr <= beat_vld & beat_eop;
        end
    end

    //******************************
    // frame stats
    //******************************
    assign eop_wr = axi2fifo_wr & axi2fifo_wdata[`EOP_POS];

    always_ff @(posedge clk_sys or posedge rst) begin
        if (rst) begin
            frame_len  <= '0;
            frm_cnt_en <= 1'b0;
        end else begin
            if (eop_wr) begin
                frame_len <= axi2fifo_wdata[`FIFO_WORD_WIDTH-1:`LEN_POS];
            end
            frm_cnt_en <= eop_wr;
        end
    end

endmodule

// File: rtl/strb_mod_enc.sv
//******************************
// beat data register and
// strobe to tail count encoder
//******************************

`timescale 1ns/1ps
`include "axi_fifo_defs.svh"

module strb_mod_enc (
    input  logic                clk_sys,
    input  logic                beat_acc,
    input  axi_fifo_pkg::data_t m_wdata,
    input  axi_fifo_pkg::strb_t m_wstrb,
    output axi_fifo_pkg::data_t beat_data,
    output axi_fifo_pkg::mod_t  beat_mod
);

    // n low ones give 64 - n unused bytes, anything else counts as full
    function automatic axi_fifo_pkg::mod_t strb_to_mod(input axi_fifo_pkg::strb_t strb);
        axi_fifo_pkg::mod_t  mod;
        axi_fifo_pkg::strb_t mask;
        mod = '0;
        for (int n = 1; n < `AXI_DATA_BYTES; n++) begin
            mask = (axi_fifo_pkg::strb_t'(1) << n) - axi_fifo_pkg::strb_t'(1);
            if (strb == mask) begin
                mod = axi_fifo_pkg::mod_t'(`AXI_DATA_BYTES - n);
            end
        end
        return mod;
    endfunction

    // stage 1, lines up with beat_vld from the control block
    always_ff @(posedge clk_sys) begin
        if (beat_acc) begin
            beat_data <= m_wdata;
            beat_mod  <= strb_to_mod(m_wstrb);
        end
    end

endmodule

// File: run_sim.sh
#!/usr/bin/env bash
# Build and run the AXI to FIFO bridge testbench with Verilator.
set -e

cd "$(dirname "$0")"

rm -rf obj_dir sim.log

verilator --binary --timing --assert \
    -f build.f \
    --top-module tb_axi_fifo_bridge \
    --Mdir obj_dir -o sim_tb

./obj_dir/sim_tb > sim.log 2>&1 || echo "simulator exited with a nonzero status"
cat sim.log

if grep -qx "Finished with no errors" sim.log; then
    echo "PASS"
    exit 0
else
    echo "FAIL"
    exit 1
fi

// File: verif/axi_fifo_bridge_asserts.sv
//******************************
// handshake assertions for the
// axi to fifo bridge, bound to the top
//******************************

`timescale 1ns/1ps
`include "axi_fifo_defs.svh"

module axi_fifo_bridge_asserts (
    input logic                     clk_sys,
    input logic                     rst,
    input logic                     s_awready,
    input logic                     s_wready,
    input logic                     s_bvalid,
    input logic                     m_bready,
    input logic                     axi2fifo_wr,
    input logic                     axi2fifo_cmd_wr,
    input axi_fifo_pkg::fifo_word_t axi2fifo_wdata
);

    // response must wait for the master
    assert property (@(posedge clk_sys) disable iff (rst)
        s_bvalid && !m_bready |=> s_bvalid)
        else $error("s_bvalid dropped before m_bready");

    // address and data phases never overlap
    assert property (@(posedge clk_sys) disable iff (rst)
        !(s_awready && s_wready))
        else $error("s_awready and s_wready high together");

    assert property (@(posedge clk_sys) disable iff (rst)
        axi2fifo_cmd_wr |-> axi2fifo_wr && axi2fifo_wdata[`EOP_POS])
        else $error("command write without an eop word");

endmodule

bind axi_fifo_bridge axi_fifo_bridge_asserts u_asserts (
    .clk_sys         (clk_sys),
    .rst             (rst),
    .s_awready       (s_awready),
    .s_wready        (s_wready),
    .s_bvalid        (s_bvalid),
    .m_bready        (m_bready),
    .axi2fifo_wr     (axi2fifo_wr),
    .axi2fifo_cmd_wr (axi2fifo_cmd_wr),
    .axi2fifo_wdata  (axi2fifo_wdata)
);

// File: verif/tb_axi_fifo_bridge.sv
//******************************
// testbench for the axi to fifo bridge
// random bursts checked against a queue model
//******************************

`timescale 1ns/1ps
`include "axi_fifo_defs.svh"

module tb_axi_fifo_bridge;

    localparam int NUM_BURSTS = 40;
    localparam int MAX_CYCLES = NUM_BURSTS * 30 + 200;

    logic                     clk_sys;
    logic                     rst;
    axi_fifo_pkg::id_t        m_awid;
    axi_fifo_pkg::addr_t      m_awaddr;
    axi_fifo_pkg::burst_len_t m_awlen;
    axi_fifo_pkg::size_t      m_awsize;
    logic                     m_awvalid;
    logic                     s_awready;
    axi_fifo_pkg::data_t      m_wdata;
    axi_fifo_pkg::strb_t      m_wstrb;
    logic                     m_wlast;
    logic                     m_wvalid;
    logic                     s_wready;
    axi_fifo_pkg::id_t        s_bid;
    logic                     s_bvalid;
    logic                     m_bready;
    logic                     axi2fifo_wr;
    axi_fifo_pkg::fifo_word_t axi2fifo_wdata;
    logic                     fifo2axi_ff;
    logic                     axi2fifo_cmd_wr;
    axi_fifo_pkg::cmd_word_t  axi2fifo_cmd_wdata;
    logic                     fifo2axi_cmd_ff;
    axi_fifo_pkg::len_t       frame_len;
    logic                     tran_cnt_en;
    logic                     tranok_cnt_en;
    logic                     frm_cnt_en;

    // model queues, filled by the driver and drained by the monitor
    axi_fifo_pkg::fifo_word_t exp_words[$];
    axi_fifo_pkg::cmd_word_t  exp_cmds[$];
    axi_fifo_pkg::len_t       exp_lens[$];

    logic [31:0] rng_state;
    int          errors;
    int          n_words;
    int          n_tran;
    int          n_tranok;
    int          n_frm;
    int          cycles;

    axi_fifo_bridge u_dut (.*);

    initial begin
        clk_sys = 1'b0;
        forever #50 clk_sys = ~clk_sys;
    end

    function automatic logic [31:0] next_rand();
        rng_state = rng_state ^ (rng_state << 13);
        rng_state = rng_state ^ (rng_state >> 17);
        rng_state = rng_state ^ (rng_state << 5);
        return rng_state;
    endfunction

    //******************************
    // checks
    //******************************
    task automatic report_fail(input string what);
        errors++;
        $display("FAILURE at %0t: %s", $time, what);
    endtask

    task automatic check_word(input axi_fifo_pkg::fifo_word_t got,
                              input axi_fifo_pkg::fifo_word_t exp);
        if (got !== exp) begin
            errors++;
            $display("[ERROR] %0t axi2fifo_wdata got %h exp %h", $time, got, exp);
        end
    endtask

    task automatic check_cmd(input axi_fifo_pkg::cmd_word_t got,
                             input axi_fifo_pkg::cmd_word_t exp);
        if (got !== exp) begin
            errors++;
            $display("[ERROR] %0t axi2fifo_cmd_wdata got %h exp %h", $time, got, exp);
        end
    endtask

    task automatic check_id(input axi_fifo_pkg::id_t got, input axi_fifo_pkg::id_t exp);
        if (got !== exp) begin
            errors++;
            $display("[ERROR] %0t s_bid got %h exp %h", $time, got, exp);
        end
    endtask

    task automatic check_len(input axi_fifo_pkg::len_t got, input axi_fifo_pkg::len_t exp);
        if (got !== exp) begin
            errors++;
            $display("[ERROR] %0t frame_len got %0d exp %0d", $time, got, exp);
        end
    endtask

    task automatic check_count(input string name, input int got, input int exp);
        if (got != exp) begin
            errors++;
            $display("[ERROR] %0t %s pulses got %0d exp %0d", $time, name, got, exp);
        end
    endtask

    //******************************
    // driver tasks
    //******************************
    // optional full period first, then the address waits for s_awready
    task automatic drive_addr(input axi_fifo_pkg::burst_len_t len,
                              input axi_fifo_pkg::id_t id,
                              input axi_fifo_pkg::addr_t addr,
                              input axi_fifo_pkg::size_t size,
                              input int ff_hold);
        int   hold;
        logic ff_seen;
        logic done;
        hold = ff_hold;
        if (hold > 0) begin
            fifo2axi_ff = 1'b1;
            @(negedge clk_sys);
        end
        m_awvalid = 1'b1;
        m_awid    = id;
        m_awaddr  = addr;
        m_awlen   = len;
        m_awsize  = size;
        done      = 1'b0;
        while (!done) begin
            // level the DUT saw on the edge just past
            ff_seen = fifo2axi_ff;
            if (hold > 0) begin
                hold--;
            end
            if (hold == 0) begin
                fifo2axi_ff = 1'b0;
            end
            if (s_awready) begin
                if (ff_seen) begin
                    report_fail("address accepted while the data FIFO was full");
                end
                done = 1'b1;
            end
            @(negedge clk_sys);
        end
        m_awvalid = 1'b0;
    endtask

    task automatic drive_beats(input axi_fifo_pkg::burst_len_t len,
                               input axi_fifo_pkg::addr_t addr);
        int                       beat;
        int                       n;
        logic                     last;
        logic                     sop;
        axi_fifo_pkg::data_t      data;
        axi_fifo_pkg::strb_t      strb;
        axi_fifo_pkg::mod_t       mod;
        axi_fifo_pkg::len_t       word_len;
        beat = 0;
        while (beat <= int'(len)) begin
            if (next_rand() % 4 == 0) begin
                m_wvalid = 1'b0;
                m_wlast  = 1'b0;
            end else begin
                last = (beat == int'(len));
                sop  = (beat == 0);
                for (int i = 0; i < 16; i++) begin
                    data[i*32 +: 32] = next_rand();
                end
                strb = '1;
                mod  = '0;
                if (last) begin
                    if (next_rand() % 4 == 0) begin
                        // bit 0 clear, never a run of low ones
                        strb = axi_fifo_pkg::strb_t'({next_rand(), next_rand()});
                        strb[0] = 1'b0;
                    end else begin
                        n    = 1 + int'(next_rand() % 64);
                        strb = '0;
                        for (int b = 0; b < n; b++) begin
                            strb[b] = 1'b1;
                        end
                        if (n < 64) begin
                            mod = axi_fifo_pkg::mod_t'(64 - n);
                        end
                    end
                end
                m_wvalid = 1'b1;
                m_wdata  = data;
                m_wstrb  = strb;
                m_wlast  = last;
                if (s_wready) begin
                    word_len = axi_fifo_pkg::len_t'((int'(len) + 1) * 64 - int'(mod));
                    exp_words.push_back({word_len, addr[3:0], sop, last, mod, data});
                    if (last) begin
                        exp_lens.push_back(word_len);
                    end
                    beat++;
                end
            end
            @(negedge clk_sys);
        end
        m_wvalid = 1'b0;
        m_wlast  = 1'b0;
    endtask

    task automatic take_resp(input axi_fifo_pkg::id_t id);
        int delay;
        delay = int'(next_rand() % 4);
        while (!s_bvalid) begin
            @(negedge clk_sys);
        end
        repeat (delay) @(negedge clk_sys);
        m_bready = 1'b1;
        check_id(s_bid, id);
        @(negedge clk_sys);
        m_bready = 1'b0;
    endtask

    //******************************
    // output monitor
    //******************************
    initial begin
        forever begin
            @(negedge clk_sys);
            if (!rst) begin
                if (axi2fifo_wr) begin
                    n_words++;
                    if (exp_words.size() == 0) begin
                        report_fail("FIFO write with no word expected");
                    end else begin
                        check_word(axi2fifo_wdata, exp_words.pop_front());
                    end
                end
                if (axi2fifo_cmd_wr != (axi2fifo_wr && axi2fifo_wdata[`EOP_POS])) begin
                    report_fail("command write not aligned with the eop word");
                end
                if (axi2fifo_cmd_wr) begin
                    if (exp_cmds.size() == 0) begin
                        report_fail("command write with no command expected");
                    end else begin
                        check_cmd(axi2fifo_cmd_wdata, exp_cmds.pop_front());
                    end
                end
                if (frm_cnt_en) begin
                    n_frm++;
                    if (exp_lens.size() == 0) begin
                        report_fail("frame pulse with no frame expected");
                    end else begin
                        check_len(frame_len, exp_lens.pop_front());
                    end
                end
                if (tran_cnt_en) begin
                    n_tran++;
                end
                if (tranok_cnt_en) begin
                    n_tranok++;
                end
            end
        end
    end

    initial begin
        cycles = 0;
        while (cycles < MAX_CYCLES) begin
            @(posedge clk_sys);
            cycles++;
        end
        $display("FAILURE: run did not finish within %0d cycles", MAX_CYCLES);
        $display("Finished with errors");
        $finish;
    end

    //******************************
    // main sequence
    //******************************
    initial begin
        axi_fifo_pkg::burst_len_t len;
        axi_fifo_pkg::id_t        id;
        axi_fifo_pkg::addr_t      addr;
        axi_fifo_pkg::size_t      size;
        int                       ff_hold;
        int                       err_before;
        string                    verdict;
        rng_state       = 32'hc7a0;
        errors          = 0;
        n_words         = 0;
        n_tran          = 0;
        n_tranok        = 0;
        n_frm           = 0;
        rst             = 1'b1;
        m_awid          = '0;
        m_awaddr        = '0;
        m_awlen         = '0;
        m_awsize        = '0;
        m_awvalid       = 1'b0;
        m_wdata         = '0;
        m_wstrb         = '0;
        m_wlast         = 1'b0;
        m_wvalid        = 1'b0;
        m_bready        = 1'b0;
        fifo2axi_ff     = 1'b0;
        fifo2axi_cmd_ff = 1'b0;
        repeat (4) @(posedge clk_sys);
        @(negedge clk_sys);
        rst = 1'b0;
        @(negedge clk_sys);

        for (int b = 0; b < NUM_BURSTS; b++) begin
            err_before = errors;
            len  = axi_fifo_pkg::burst_len_t'(next_rand() % 8);
            id   = axi_fifo_pkg::id_t'(next_rand());
            addr = axi_fifo_pkg::addr_t'({next_rand(), next_rand()});
            size = axi_fifo_pkg::size_t'(next_rand() % 8);
            ff_hold = 0;
            if (next_rand() % 3 == 0) begin
                ff_hold = 1 + int'(next_rand() % 4);
            end
            exp_cmds.push_back({len, size, id, addr});
            drive_addr(len, id, addr, size, ff_hold);
            drive_beats(len, addr);
            take_resp(id);
            // let the eop word and frame length drain
            while (exp_lens.size() != 0) begin
                @(negedge clk_sys);
            end
            if (errors == err_before) begin
                verdict = "ok";
            end else begin
                verdict = "FAILED";
            end
            $display("burst %0d: %0d beats id %h full hold %0d %s",
                     b, int'(len) + 1, id, ff_hold, verdict);
        end

        repeat (2) @(negedge clk_sys);
        if (exp_words.size() != 0 || exp_cmds.size() != 0) begin
            report_fail("expected FIFO or command writes never arrived");
        end
        check_count("tran_cnt_en", n_tran, NUM_BURSTS);
        check_count("tranok_cnt_en", n_tranok, NUM_BURSTS);
        check_count("frm_cnt_en", n_frm, NUM_BURSTS);
        $display("bursts %0d words %0d tran %0d tranok %0d frm %0d errors %0d",
                 NUM_BURSTS, n_words, n_tran, n_tranok, n_frm, errors);
        if (errors == 0) begin
            $display("Finished with no errors");
        end else begin
            $display("Finished with errors");
        end
        $finish;
    end

endmodule
